// ==== rtl/ecc_pkg.sv ====
/* ecc word store constants */

package ecc_pkg;

    // data and codeword widths
    localparam int data_width = 8;
    localparam int parity_bits = 4;
    localparam int code_width = 13;

    // storage
    localparam int store_depth = 16;
    localparam int addr_width = 4;

    // decoder
    localparam int syndrome_width = 4;

    // positions 1..12 live in bits 0..11, overall parity above them
    localparam int hamming_len = 12;

    // data bit i lands at this codeword index
    // parity k sits at index 2**k - 1 (0, 1, 3, 7)
    localparam int data_pos [data_width] = '{
        2,
        4,
        5,
        6,
        8,
        9,
        10,
        11
    };

endpackage

// ==== rtl/hamming_encoder.sv ====
/* SEC-DED Hamming encoder */

module hamming_encoder (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             wr_en,
    input  logic [ecc_pkg::addr_width-1:0]   wr_addr,
    input  logic [ecc_pkg::data_width-1:0]   wr_data,
    input  logic [ecc_pkg::code_width-1:0]   flip_mask,
    output logic                             enc_valid,
    output logic [ecc_pkg::addr_width-1:0]   enc_addr,
    output logic [ecc_pkg::code_width-1:0]   enc_code,
    output logic [ecc_pkg::code_width-1:0]   enc_mask
);

    logic [ecc_pkg::code_width-1:0] code_c;

    // place data, then fill in the parity slots
    always_comb begin
        logic acc;
        code_c = '0;
        for (int i = 0; i < ecc_pkg::data_width; i++) begin
            code_c[ecc_pkg::data_pos[i]] = wr_data[i];
        end
        // parity slots are still zero here, so covering them is harmless
        for (int k = 0; k < ecc_pkg::parity_bits; k++) begin
            acc = 1'b0;
            for (int i = 0; i < ecc_pkg::hamming_len; i++) begin
                if (((i + 1) & (1 << k)) != 0) begin
                    acc = acc ^ code_c[i];
                end
            end
            code_c[(1 << k) - 1] = acc;
        end
        // overall parity for double error detection
        code_c[ecc_pkg::hamming_len] = ^code_c[ecc_pkg::hamming_len-1:0];
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            enc_valid <= 1'b0;
        end else begin
            enc_valid <= wr_en;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            enc_addr <= wr_addr;
            enc_code <= code_c;
            enc_mask <= flip_mask;
        end
    end

endmodule

// ==== rtl/code_store.sv ====
/* codeword memory */

module code_store (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             enc_valid,
    input  logic [ecc_pkg::addr_width-1:0]   enc_addr,
    input  logic [ecc_pkg::code_width-1:0]   enc_code,
    input  logic [ecc_pkg::code_width-1:0]   enc_mask,
    input  logic                             rd_en,
    input  logic [ecc_pkg::addr_width-1:0]   rd_addr,
    output logic                             st_valid,
    output logic [ecc_pkg::code_width-1:0]   st_code
);

    logic [ecc_pkg::code_width-1:0] mem [ecc_pkg::store_depth];

    // mask bits corrupt the stored word
    always_ff @(posedge clk) begin
        if (enc_valid) begin
            mem[enc_addr] <= enc_code ^ enc_mask;
        end
    end

    // same-address write and read returns the old word
    always_ff @(posedge clk) begin
        if (rd_en) begin
            st_code <= mem[rd_addr];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            st_valid <= 1'b0;
        end else begin
            st_valid <= rd_en;
        end
    end

endmodule

// ==== rtl/hamming_decoder.sv ====
/* SEC-DED syndrome decoder */

module hamming_decoder (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 st_valid,
    input  logic [ecc_pkg::code_width-1:0]       st_code,
    output logic                                 rd_valid,
    output logic [ecc_pkg::data_width-1:0]       rd_data,
    output logic                                 single_err,
    output logic                                 double_err,
    output logic [ecc_pkg::syndrome_width-1:0]   syndrome
);

    logic [ecc_pkg::syndrome_width-1:0] syn_c;
    logic                               overall_bad;
    logic [ecc_pkg::code_width-1:0]     fixed_c;
    logic [ecc_pkg::data_width-1:0]     data_c;
    logic                               single_c;
    logic                               double_c;

    // syndrome bit k checks every position with bit k set
    always_comb begin
        for (int k = 0; k < ecc_pkg::syndrome_width; k++) begin
            syn_c[k] = 1'b0;
            for (int i = 0; i < ecc_pkg::hamming_len; i++) begin
                if (((i + 1) & (1 << k)) != 0) begin
                    syn_c[k] = syn_c[k] ^ st_code[i];
                end
            end
        end
    end

    // includes the overall bit itself
    assign overall_bad = ^st_code;

    always_comb begin
        fixed_c = st_code;
        single_c = 1'b0;
        double_c = 1'b0;
        if (overall_bad) begin
            if (syn_c == '0) begin
                // only the overall bit flipped
                single_c = 1'b1;
            end else if (int'(syn_c) <= ecc_pkg::hamming_len) begin
                single_c = 1'b1;
                for (int i = 0; i < ecc_pkg::hamming_len; i++) begin
                    if (int'(syn_c) == i + 1) begin
                        fixed_c[i] = ~st_code[i];
                    end
                end
            end else begin
                // points past the word, cannot be a single error
                double_c = 1'b1;
            end
        end else if (syn_c != '0) begin
            double_c = 1'b1;
        end
    end

    always_comb begin
        for (int i = 0; i < ecc_pkg::data_width; i++) begin
            data_c[i] = fixed_c[ecc_pkg::data_pos[i]];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
            single_err <= 1'b0;
            double_err <= 1'b0;
        end else begin
            rd_valid <= st_valid;
            // flags only mean something alongside rd_valid
            single_err <= st_valid & single_c;
            double_err <= st_valid & double_c;
        end
    end

    always_ff @(posedge clk) begin
        if (st_valid) begin
            rd_data <= data_c;
            syndrome <= syn_c;
        end
    end

endmodule

// ==== rtl/ecc_ram.sv ====
/* ECC protected word store */

module ecc_ram (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 wr_en,
    input  logic [ecc_pkg::addr_width-1:0]       wr_addr,
    input  logic [ecc_pkg::data_width-1:0]       wr_data,
    input  logic [ecc_pkg::code_width-1:0]       flip_mask,
    input  logic                                 rd_en,
    input  logic [ecc_pkg::addr_width-1:0]       rd_addr,
    output logic                                 rd_valid,
    output logic [ecc_pkg::data_width-1:0]       rd_data,
    output logic                                 single_err,
    output logic                                 double_err,
    output logic [ecc_pkg::syndrome_width-1:0]   syndrome
);

    // write path
    logic                            enc_valid;
    logic [ecc_pkg::addr_width-1:0]  enc_addr;
    logic [ecc_pkg::code_width-1:0]  enc_code;
    logic [ecc_pkg::code_width-1:0]  enc_mask;

    // read path
    logic                            st_valid;
    logic [ecc_pkg::code_width-1:0]  st_code;

    hamming_encoder i_hamming_encoder (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .flip_mask (flip_mask),
        .enc_valid (enc_valid),
        .enc_addr  (enc_addr),
        .enc_code  (enc_code),
        .enc_mask  (enc_mask)
    );

    code_store i_code_store (
        .clk       (clk),
        .rst_n     (rst_n),
        .enc_valid (enc_valid),
        .enc_addr  (enc_addr),
        .enc_code  (enc_code),
        .enc_mask  (enc_mask),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .st_valid  (st_valid),
        .st_code   (st_code)
    );

    hamming_decoder i_hamming_decoder (
        .clk        (clk),
        .rst_n      (rst_n),
        .st_valid   (st_valid),
        .st_code    (st_code),
        .rd_valid   (rd_valid),
        .rd_data    (rd_data),
        .single_err (single_err),
        .double_err (double_err),
        .syndrome   (syndrome)
    );

endmodule

// ==== tests/ecc_ram_props.sv ====
/* ecc_ram protocol assertions */

module ecc_ram_props (
    input logic clk,
    input logic rst_n,
    input logic rd_en,
    input logic rd_valid,
    input logic single_err,
    input logic double_err
);

    read_latency: assert property (@(posedge clk) disable iff (!rst_n)
        rd_valid == $past(rd_en, 2))
        else $error("rd_valid does not follow rd_en by two cycles");

    one_flag_only: assert property (@(posedge clk) disable iff (!rst_n)
        !(single_err && double_err))
        else $error("single_err and double_err both high");

    // flags only travel with a read result
    flags_need_valid: assert property (@(posedge clk) disable iff (!rst_n)
        !rd_valid |-> (!single_err && !double_err))
        else $error("error flag high while rd_valid is low");

endmodule

bind ecc_ram ecc_ram_props i_ecc_ram_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .rd_en      (rd_en),
    .rd_valid   (rd_valid),
    .single_err (single_err),
    .double_err (double_err)
);

// ==== tests/tb_clock_gen.sv ====
/* testbench clock and reset */

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// ==== tests/ecc_checker.sv ====
/* read result checker */

module ecc_checker (
    input logic                                 clk,
    input logic                                 rst_n,
    input logic                                 rd_valid,
    input logic [ecc_pkg::data_width-1:0]       rd_data,
    input logic                                 single_err,
    input logic                                 double_err,
    input logic [ecc_pkg::syndrome_width-1:0]   syndrome
);

    string                          name_q [$];
    logic [ecc_pkg::data_width-1:0] data_q [$];
    logic [ecc_pkg::code_width-1:0] mask_q [$];
    logic                           single_q [$];
    logic                           double_q [$];
    int done_count = 0;
    int pass_count = 0;
    int fail_count = 0;
    int stray_count = 0;

    // xor of the position numbers of all set bits in positions 1..12
    function automatic logic [3:0] position_xor(input logic [ecc_pkg::code_width-1:0] c);
        logic [3:0] acc;
        acc = 4'd0;
        for (int j = 0; j < ecc_pkg::code_width - 1; j++) begin
            if (c[j]) begin
                acc = acc ^ 4'(j + 1);
            end
        end
        return acc;
    endfunction

    function automatic logic [ecc_pkg::code_width-1:0] build_codeword(
        input logic [ecc_pkg::data_width-1:0] d
    );
        logic [ecc_pkg::code_width-1:0] c;
        logic [3:0] p;
        int n;
        c = '0;
        n = 0;
        for (int j = 0; j < ecc_pkg::code_width - 1; j++) begin
            if (((j + 1) & j) != 0) begin
                c[j] = d[n];
                n++;
            end
        end
        // parity bits cancel the position xor of the data bits
        p = position_xor(c);
        c[0] = p[0];
        c[1] = p[1];
        c[3] = p[2];
        c[7] = p[3];
        c[12] = ^c[11:0];
        return c;
    endfunction

    task automatic push_expected(input string name, input logic [7:0] data,
                                 input logic [12:0] mask, input logic s, input logic d);
        name_q.push_back(name);
        data_q.push_back(data);
        mask_q.push_back(mask);
        single_q.push_back(s);
        double_q.push_back(d);
    endtask

    task automatic close_idle_test(input string name);
        if (stray_count == 0) begin
            pass_count++;
            $display("test %s: pass", name);
        end else begin
            fail_count++;
            $display("test %s: fail, outputs moved with no read issued", name);
        end
    endtask

    task automatic check_read();
        string name;
        logic [ecc_pkg::code_width-1:0] stored;
        logic [ecc_pkg::code_width-1:0] fixed;
        logic [7:0] exp_data;
        logic [3:0] exp_syn;
        logic exp_single;
        logic exp_double;
        int n;
        bit bad;
        name = name_q.pop_front();
        stored = build_codeword(data_q.pop_front()) ^ mask_q.pop_front();
        exp_single = single_q.pop_front();
        exp_double = double_q.pop_front();
        exp_syn = position_xor(stored);
        fixed = stored;
        // bad overall parity with a position in range is one flipped bit
        if ((^stored) && exp_syn != 4'd0 && exp_syn <= 4'd12) begin
            fixed[int'(exp_syn) - 1] = ~stored[int'(exp_syn) - 1];
        end
        n = 0;
        exp_data = '0;
        for (int j = 0; j < ecc_pkg::code_width - 1; j++) begin
            if (((j + 1) & j) != 0) begin
                exp_data[n] = fixed[j];
                n++;
            end
        end
        bad = 1'b0;
        if (rd_data !== exp_data) begin
            $display("** Error %s: data expected %h, actual %h", name, exp_data, rd_data);
            bad = 1'b1;
        end
        if (syndrome !== exp_syn) begin
            $display("** Error %s: syndrome expected %0d, actual %0d", name, exp_syn, syndrome);
            bad = 1'b1;
        end
        if (single_err !== exp_single) begin
            $display("** Error %s: single_err expected %b, actual %b", name, exp_single,
                     single_err);
            bad = 1'b1;
        end
        if (double_err !== exp_double) begin
            $display("** Error %s: double_err expected %b, actual %b", name, exp_double,
                     double_err);
            bad = 1'b1;
        end
        if (bad) begin
            fail_count++;
            $display("test %s: fail", name);
        end else begin
            pass_count++;
            $display("test %s: pass", name);
        end
        done_count++;
    endtask

    // sample away from the rising edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (!rd_valid && (single_err || double_err)) begin
                $display("error flag raised while rd_valid is low");
                stray_count++;
            end
            if (rd_valid && name_q.size() == 0) begin
                $display("rd_valid seen with no read outstanding");
                stray_count++;
            end else if (rd_valid) begin
                check_read();
            end
        end
    end

endmodule

// ==== tests/ecc_ram_tb.sv ====
/* ecc_ram testbench */

module ecc_ram_tb;

    localparam int read_timeout = 16;

    logic                               clk;
    logic                               rst_n;
    logic                               wr_en;
    logic [ecc_pkg::addr_width-1:0]     wr_addr;
    logic [ecc_pkg::data_width-1:0]     wr_data;
    logic [ecc_pkg::code_width-1:0]     flip_mask;
    logic                               rd_en;
    logic [ecc_pkg::addr_width-1:0]     rd_addr;
    logic                               rd_valid;
    logic [ecc_pkg::data_width-1:0]     rd_data;
    logic                               single_err;
    logic                               double_err;
    logic [ecc_pkg::syndrome_width-1:0] syndrome;

    // what each address holds, for building expectations
    logic [ecc_pkg::data_width-1:0] shadow_data [ecc_pkg::store_depth];
    logic [ecc_pkg::code_width-1:0] shadow_mask [ecc_pkg::store_depth];
    logic [31:0] rng;
    int issued = 0;
    bit aborted = 1'b0;

    tb_clock_gen i_clock_gen (.clk(clk), .rst_n(rst_n));

    ecc_ram i_ecc_ram (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .flip_mask  (flip_mask),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_valid   (rd_valid),
        .rd_data    (rd_data),
        .single_err (single_err),
        .double_err (double_err),
        .syndrome   (syndrome)
    );

    ecc_checker i_checker (
        .clk        (clk),
        .rst_n      (rst_n),
        .rd_valid   (rd_valid),
        .rd_data    (rd_data),
        .single_err (single_err),
        .double_err (double_err),
        .syndrome   (syndrome)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    task automatic write_word(input logic [3:0] addr, input logic [7:0] data,
                              input logic [12:0] mask);
        @(posedge clk);
        wr_en <= 1'b1;
        wr_addr <= addr;
        wr_data <= data;
        flip_mask <= mask;
        shadow_data[addr] = data;
        shadow_mask[addr] = mask;
        @(posedge clk);
        wr_en <= 1'b0;
        flip_mask <= '0;
    endtask

    task automatic issue_read(input logic [3:0] addr, input string name,
                              input logic s, input logic d);
        @(posedge clk);
        rd_en <= 1'b1;
        rd_addr <= addr;
        i_checker.push_expected(name, shadow_data[addr], shadow_mask[addr], s, d);
        issued++;
    endtask

    task automatic finish_reads(input string what);
        int cycles;
        @(posedge clk);
        rd_en <= 1'b0;
        cycles = 0;
        while (i_checker.done_count < issued && cycles < read_timeout) begin
            @(negedge clk);
            cycles++;
        end
        if (i_checker.done_count < issued) begin
            $display("timeout: %s got no rd_valid within %0d cycles", what, read_timeout);
            aborted = 1'b1;
        end
    endtask

    task automatic run_file_tests();
        int fd;
        int n;
        int addr, data, mask, s, d;
        string line;
        string name;
        fd = $fopen("tests/ecc_ram_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open tests/ecc_ram_tests.txt");
            aborted = 1'b1;
        end else begin
            while (!aborted && !$feof(fd)) begin
                n = $fgets(line, fd);
                // skip header and blank lines
                if (n > 0 && line.len() > 0 && line[0] != "#" &&
                        $sscanf(line, "%s %h %h %h %d %d", name, addr, data, mask, s, d) == 6) begin
                    write_word(addr[3:0], data[7:0], mask[12:0]);
                    issue_read(addr[3:0], name, s[0], d[0]);
                    finish_reads(name);
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        int cycles;
        wr_en = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        flip_mask = '0;
        rd_en = 1'b0;
        rd_addr = '0;
        rng = 32'hd591_343f;
        cycles = 0;
        while (rst_n !== 1'b1 && cycles < 10) begin
            @(posedge clk);
            cycles++;
        end
        if (rst_n !== 1'b1) begin
            $display("reset was never released");
            aborted = 1'b1;
        end
        // quiet period, nothing may come out
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
        end
        i_checker.close_idle_test("idle_after_reset");
        if (!aborted) begin
            run_file_tests();
        end
        for (int a = 0; a < ecc_pkg::store_depth && !aborted; a++) begin
            rng = xorshift32(rng);
            write_word(a[3:0], rng[7:0], '0);
            issue_read(a[3:0], $sformatf("random_addr_%0d", a), 1'b0, 1'b0);
            finish_reads($sformatf("random_addr_%0d", a));
        end
        // one read per cycle, descending addresses
        if (!aborted) begin
            for (int a = 0; a < ecc_pkg::store_depth; a++) begin
                rd_addr_burst(a);
            end
            finish_reads("burst");
        end
        $display("tests: %0d passed, %0d failed, %0d stray events", i_checker.pass_count,
                 i_checker.fail_count, i_checker.stray_count);
        if (aborted || i_checker.fail_count != 0 || i_checker.stray_count != 0) begin
            $display("Result: FAILED");
        end else begin
            $display("Result: PASSED");
        end
        $finish;
    end

    task automatic rd_addr_burst(input int a);
        int addr;
        addr = ecc_pkg::store_depth - 1 - a;
        issue_read(addr[3:0], $sformatf("burst_%0d", a), 1'b0, 1'b0);
    endtask

endmodule

// ==== all.f ====
rtl/ecc_pkg.sv
rtl/hamming_encoder.sv
rtl/code_store.sv
rtl/hamming_decoder.sv
rtl/ecc_ram.sv
tests/ecc_ram_props.sv
tests/tb_clock_gen.sv
tests/ecc_checker.sv
tests/ecc_ram_tb.sv

// ==== Makefile ====
# Verilator build and run for the ECC word store

VERILATOR ?= verilator
TOP       ?= ecc_ram_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= Result: PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tests/ecc_ram_tests.txt ====
# name addr data flip_mask exp_single exp_double
# addr, data and flip_mask in hex, flags 0 or 1
clean_zero 0 00 0000 0 0
clean_ones f ff 0000 0 0
clean_alt 5 a5 0000 0 0
flip_pos1 1 3c 0001 1 0
flip_pos2 2 c3 0002 1 0
flip_pos3 3 5a 0004 1 0
flip_pos4 4 81 0008 1 0
flip_pos5 6 7e 0010 1 0
flip_pos6 7 01 0020 1 0
flip_pos7 8 80 0040 1 0
flip_pos8 9 e7 0080 1 0
flip_pos9 a 18 0100 1 0
flip_pos10 b 96 0200 1 0
flip_pos11 c 69 0400 1 0
flip_pos12 d f0 0800 1 0
flip_overall e 0f 1000 1 0
double_pos1_pos2 0 55 0003 0 1
double_pos3_pos12 3 aa 0804 0 1
double_pos7_pos11 6 c6 0440 0 1
double_pos5_overall 9 2d 1010 0 1
double_pos4_pos8 c 00 0088 0 1
triple_beyond_word 1 b4 0089 0 1
